// ==== fetch_frontend.f ====
logic/fetch_pkg.sv
logic/fetch_stage_if.sv
logic/inst_fetch_axi.sv
logic/if_id_reg.sv
logic/fetch_frontend.sv
verif/fetch_frontend_chk.sv
verif/tb_fetch_frontend.sv

// ==== logic/fetch_frontend.sv ====
/*
 * Top of the instruction fetch front end.
 * Connects the AXI4-Lite fetch unit to the IF/ID register; AXI read,
 * redirect and decode signals are brought out as plain ports.
 */

`timescale 1ns/100ps

module fetch_frontend (
    input  logic                         clk,
    input  logic                         rst,

    // AXI4-Lite read address channel
    output logic [fetch_pkg::xlen-1:0]   araddr,
    output logic                         arvalid,
    input  logic                         arready,

    // AXI4-Lite read data channel
    input  logic [fetch_pkg::xlen-1:0]   rdata,
    input  logic [fetch_pkg::resp_w-1:0] rresp,
    input  logic                         rvalid,
    output logic                         rready,

    // redirect from a later stage
    input  logic                         redirect_valid,
    input  logic [fetch_pkg::xlen-1:0]   redirect_pc,

    // decode control
    input  logic                         id_stall,
    input  logic                         id_bubble,

    // IF/ID outputs to decode
    output logic [fetch_pkg::xlen-1:0]   id_pc,
    output logic [fetch_pkg::xlen-1:0]   id_inst,
    output logic                         id_fault,
    output logic                         id_valid
);

    // fetch unit to IF/ID link
    fetch_stage_if u_fetch_if ();

    inst_fetch_axi u_fetch (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .fetch          (u_fetch_if)
    );

    if_id_reg u_if_id (
        .clk       (clk),
        .rst       (rst),
        .id_stall  (id_stall),
        .id_bubble (id_bubble),
        .fetch     (u_fetch_if),
        .id_pc     (id_pc),
        .id_inst   (id_inst),
        .id_fault  (id_fault),
        .id_valid  (id_valid)
    );

endmodule

// ==== logic/fetch_pkg.sv ====
/*
 * Shared constants for the instruction fetch front end.
 * Bus widths, the boot address, the NOP encoding and AXI read responses.
 * Reference these by scoped name from any block that needs them.
 */

package fetch_pkg;

    // address and data width of the core and the AXI read path
    localparam int xlen = 32;

    // width of the AXI response field
    localparam int resp_w = 2;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // pc increment for each sequential instruction
    localparam logic [xlen-1:0] inst_step = 32'd4;

    // addi x0, x0, 0
    // every empty slot in IF/ID carries this encoding
    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

    // AXI4-Lite read responses
    localparam logic [resp_w-1:0] resp_okay   = 2'b00;  // normal access
    localparam logic [resp_w-1:0] resp_slverr = 2'b10;  // slave error

endpackage

// ==== logic/fetch_stage_if.sv ====
/*
 * Handshake between the fetch unit and the IF/ID register.
 * Carries one instruction with its pc and fault flag, plus a flush pulse.
 * The fetch unit takes the src modport, the IF/ID register the sink.
 */

`timescale 1ns/100ps

interface fetch_stage_if;

    logic                       valid;  // instruction offered
    logic [fetch_pkg::xlen-1:0] pc;     // address of the offered instruction
    logic [fetch_pkg::xlen-1:0] inst;   // instruction word
    logic                       fault;  // bus error on this fetch
    logic                       flush;  // one-cycle pulse on redirect
    logic                       ready;  // sink takes the instruction this cycle

    // fetch unit side
    modport src (
        output valid,
        output pc,
        output inst,
        output fault,
        output flush,
        input  ready
    );

    // IF/ID side
    modport sink (
        input  valid,
        input  pc,
        input  inst,
        input  fault,
        input  flush,
        output ready
    );

endinterface

// ==== logic/if_id_reg.sv ====
/*
 * IF/ID pipeline register between fetch and decode.
 * Flushes on redirect, holds while decode stalls and inserts a NOP bubble
 * on request. Empty slots always read as nop_inst with valid low.
 */

`timescale 1ns/100ps

module if_id_reg (
    input  logic                       clk,
    input  logic                       rst,

    // decode control
    input  logic                       id_stall,   // keep current contents
    input  logic                       id_bubble,  // insert a NOP this cycle

    fetch_stage_if.sink                fetch,

    // towards decode
    output logic [fetch_pkg::xlen-1:0] id_pc,
    output logic [fetch_pkg::xlen-1:0] id_inst,
    output logic                       id_fault,
    output logic                       id_valid
);

    logic take;  // offered instruction is loaded at this edge

    // flush, stall and bubble all refuse the offer
    assign take = fetch.valid & ~fetch.flush & ~id_stall & ~id_bubble;

    assign fetch.ready = take;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_pc    <= '0;
            id_inst  <= fetch_pkg::nop_inst;
            id_fault <= 1'b0;
            id_valid <= 1'b0;
        end else if (fetch.flush) begin
            // wrong-path instruction is killed
            id_pc    <= '0;
            id_inst  <= fetch_pkg::nop_inst;
            id_fault <= 1'b0;
            id_valid <= 1'b0;
        end else if (id_stall) begin
            id_pc    <= id_pc;
            id_inst  <= id_inst;
            id_fault <= id_fault;
            id_valid <= id_valid;
        end else if (id_bubble) begin
            id_pc    <= '0;
            id_inst  <= fetch_pkg::nop_inst;
            id_fault <= 1'b0;
            id_valid <= 1'b0;
        end else if (take) begin
            id_pc    <= fetch.pc;
            id_inst  <= fetch.inst;
            id_fault <= fetch.fault;
            id_valid <= 1'b1;
        end else begin
            // fetch had nothing ready
            id_pc    <= '0;
            id_inst  <= fetch_pkg::nop_inst;
            id_fault <= 1'b0;
            id_valid <= 1'b0;
        end
    end

endmodule

// ==== logic/inst_fetch_axi.sv ====
/*
 * Fetch unit with the program counter and an AXI4-Lite read master.
 * One read at a time is issued at the pc; the beat lands in a one-entry
 * buffer offered to IF/ID. A redirect reloads the pc, empties the buffer,
 * flushes IF/ID and drops any beat still on its way back.
 */

`timescale 1ns/100ps

module inst_fetch_axi (
    input  logic                         clk,
    input  logic                         rst,

    // redirect from a later stage
    input  logic                         redirect_valid,
    input  logic [fetch_pkg::xlen-1:0]   redirect_pc,

    // AXI4-Lite read address channel
    output logic [fetch_pkg::xlen-1:0]   araddr,
    output logic                         arvalid,
    input  logic                         arready,

    // AXI4-Lite read data channel
    input  logic [fetch_pkg::xlen-1:0]   rdata,
    input  logic [fetch_pkg::resp_w-1:0] rresp,
    input  logic                         rvalid,
    output logic                         rready,

    fetch_stage_if.src                   fetch
);

    logic [fetch_pkg::xlen-1:0] pc_q;
    logic [fetch_pkg::xlen-1:0] pc_next;
    logic [fetch_pkg::xlen-1:0] araddr_q;
    logic                       arvalid_q;
    logic                       outstanding_q;  // AR accepted, R not yet back
    logic                       stale_q;        // in-flight read belongs to the old path

    // one-entry fetch buffer
    logic                       buf_valid;
    logic [fetch_pkg::xlen-1:0] buf_pc;
    logic [fetch_pkg::xlen-1:0] buf_inst;
    logic                       buf_fault;

    logic ar_fire;
    logic r_fire;
    logic xfer;
    logic issue;

    assign ar_fire = arvalid_q & arready;
    assign r_fire  = rvalid & rready;
    assign xfer    = buf_valid & fetch.ready;  // instruction moves into IF/ID

    // redirect wins over the sequential step
    always_comb begin
        pc_next = pc_q;
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end else if (xfer) begin
            pc_next = pc_q + fetch_pkg::inst_step;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= fetch_pkg::reset_pc;
        end else begin
            pc_q <= pc_next;
        end
    end

    // new read only when the bus is idle and the buffer is free at this edge
    assign issue = ~arvalid_q & ~outstanding_q & (~buf_valid | xfer | redirect_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid_q <= 1'b0;
        end else if (issue) begin
            arvalid_q <= 1'b1;
        end else if (ar_fire) begin
            arvalid_q <= 1'b0;
        end
    end

    // address is frozen while arvalid is up, even across a redirect
    always_ff @(posedge clk) begin
        if (issue) begin
            araddr_q <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding_q <= 1'b0;
        end else if (ar_fire) begin
            outstanding_q <= 1'b1;
        end else if (r_fire) begin
            outstanding_q <= 1'b0;
        end
    end

    // mark a read that was already launched when the redirect arrived
    always_ff @(posedge clk) begin
        if (rst) begin
            stale_q <= 1'b0;
        end else if (redirect_valid && (arvalid_q || (outstanding_q && !r_fire))) begin
            stale_q <= 1'b1;
        end else if (r_fire) begin
            stale_q <= 1'b0;  // old-path beat has been swallowed
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (redirect_valid) begin
            buf_valid <= 1'b0;
        end else if (r_fire && !stale_q) begin
            buf_valid <= 1'b1;
        end else if (xfer) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire && !stale_q) begin
            buf_pc    <= araddr_q;
            buf_inst  <= rdata;
            buf_fault <= (rresp != fetch_pkg::resp_okay);
        end
    end

    assign araddr  = araddr_q;
    assign arvalid = arvalid_q;
    assign rready  = outstanding_q & ~buf_valid;  // no room, no beat

    assign fetch.valid = buf_valid;
    assign fetch.pc    = buf_pc;
    assign fetch.inst  = buf_inst;
    assign fetch.fault = buf_fault;
    assign fetch.flush = redirect_valid;

endmodule

// ==== verif/fetch_frontend_chk.sv ====
/*
 * Protocol checks for the fetch front end, bound into fetch_frontend.
 * Watches the AXI4-Lite read channel and the IF/ID outputs.
 */

`timescale 1ns/100ps

module fetch_frontend_chk (
    input logic                       clk,
    input logic                       rst,
    input logic [fetch_pkg::xlen-1:0] araddr,
    input logic                       arvalid,
    input logic                       arready,
    input logic                       rvalid,
    input logic                       rready,
    input logic [fetch_pkg::xlen-1:0] id_inst,
    input logic                       id_valid
);

    int unsigned fail_count = 0;
    logic        outstanding;  // AR accepted, R not yet taken

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (arvalid && arready) begin
            outstanding <= 1'b1;
        end else if (rvalid && rready) begin
            outstanding <= 1'b0;
        end
    end

    // AR must stay up with a fixed address until accepted
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("arvalid dropped or araddr moved before arready");
            fail_count++;
        end

    r_expected: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> outstanding)
        else begin
            $error("read data returned with no read outstanding");
            fail_count++;
        end

    empty_is_nop: assert property (@(posedge clk) disable iff (rst)
        !id_valid |-> id_inst == fetch_pkg::nop_inst)
        else begin
            $error("empty IF/ID slot does not hold the NOP encoding");
            fail_count++;
        end

endmodule

bind fetch_frontend fetch_frontend_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rvalid   (rvalid),
    .rready   (rready),
    .id_inst  (id_inst),
    .id_valid (id_valid)
);

// ==== verif/tb_fetch_frontend.sv ====
/*
 * Directed testbench for the fetch front end.
 * An AXI4-Lite ROM model with random handshake delays serves the reads;
 * every cycle the IF/ID outputs are compared with the expected stream.
 */

`timescale 1ns/100ps

module tb_fetch_frontend;

    localparam logic [31:0] err_addr = 32'h8000_1020;  // answers SLVERR

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready = 1'b0;
    logic [31:0] rdata = '0;
    logic [1:0]  rresp = fetch_pkg::resp_okay;
    logic        rvalid = 1'b0;
    logic        rready;
    logic        redirect_valid = 1'b0;
    logic [31:0] redirect_pc = '0;
    logic        id_stall = 1'b0;
    logic        id_bubble = 1'b0;
    logic [31:0] id_pc;
    logic [31:0] id_inst;
    logic        id_fault;
    logic        id_valid;

    // scoreboard and bookkeeping
    logic [31:0] exp_pc = fetch_pkg::reset_pc;
    int          consumed = 0;
    logic        fault_seen = 1'b0;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    // ROM model state
    int          slv_state = 0;
    logic [1:0]  slv_cnt;
    logic [31:0] slv_addr;
    logic        rr_seen;
    logic [31:0] slv_rng = 32'd24139;
    logic [31:0] stim_rng = 32'd24139;

    fetch_frontend i_dut (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // two regions with each word tagged by its index
    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        if (addr >= 32'h8000_1000 && addr < 32'h8000_2000) begin
            return 32'h2000_0000 + ((addr - 32'h8000_1000) >> 2);
        end
        if (addr >= fetch_pkg::reset_pc && addr < 32'h8000_1000) begin
            return 32'h1000_0000 + ((addr - fetch_pkg::reset_pc) >> 2);
        end
        return ~addr;
    endfunction

    // AXI4-Lite ROM slave serving one read at a time with 0-3 cycles before each ready and valid
    always @(negedge clk) begin
        if (rst) begin
            slv_state = 0;
            arready = 1'b0;
            rvalid = 1'b0;
        end else begin
            if (slv_state == 0 && arvalid) begin
                slv_rng = xorshift32(slv_rng);
                slv_cnt = slv_rng[1:0];
                slv_state = 1;
            end
            if (slv_state == 1) begin
                if (slv_cnt == 0) begin
                    arready = 1'b1;
                    slv_addr = araddr;
                    slv_state = 2;
                end else begin
                    slv_cnt = slv_cnt - 1'b1;
                end
            end else if (slv_state == 2) begin
                arready = 1'b0;  // AR taken at the last rising edge
                slv_rng = xorshift32(slv_rng);
                slv_cnt = slv_rng[1:0];
                slv_state = 3;
            end
            if (slv_state == 3) begin
                if (slv_cnt == 0) begin
                    rvalid = 1'b1;
                    rdata = rom_word(slv_addr);
                    rresp = (slv_addr == err_addr) ? fetch_pkg::resp_slverr
                                                   : fetch_pkg::resp_okay;
                    rr_seen = rready;  // rready holds until the next rising edge
                    slv_state = 4;
                end else begin
                    slv_cnt = slv_cnt - 1'b1;
                end
            end else if (slv_state == 4) begin
                if (rr_seen) begin
                    rvalid = 1'b0;
                    slv_state = 0;
                end else begin
                    rr_seen = rready;
                end
            end
        end
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // bus and decode side must be idle
    task automatic check_quiet();
        compare_bit("arvalid", arvalid, 1'b0);
        compare_bit("rready", rready, 1'b0);
        compare_bit("id_valid", id_valid, 1'b0);
    endtask

    // drive one cycle at the falling edge and check what IF/ID shows
    task automatic cycle(input logic stall, input logic bubble, input logic redir,
                         input logic [31:0] rpc);
        logic [31:0] held_pc;
        logic [31:0] held_inst;
        held_pc = id_pc;
        held_inst = id_inst;
        id_stall = stall;
        id_bubble = bubble;
        redirect_valid = redir;
        redirect_pc = rpc;
        @(negedge clk);
        if (redir) begin
            compare_bit("id_valid", id_valid, 1'b0);
            exp_pc = rpc;
        end else if (stall) begin
            compare_word("id_pc", id_pc, held_pc);
            compare_word("id_inst", id_inst, held_inst);
        end else if (bubble) begin
            compare_bit("id_valid", id_valid, 1'b0);
            compare_word("id_inst", id_inst, fetch_pkg::nop_inst);
        end
        if (id_valid && !stall && !redir) begin  // a new instruction reached decode
            compare_word("id_pc", id_pc, exp_pc);
            compare_word("id_inst", id_inst, rom_word(exp_pc));
            compare_bit("id_fault", id_fault, exp_pc == err_addr);
            if (id_fault && id_pc == err_addr) begin
                fault_seen = 1'b1;
            end
            exp_pc = exp_pc + fetch_pkg::inst_step;
            consumed++;
        end
    endtask

    task automatic wait_consumed(input int n);
        int target;
        int t;
        target = consumed + n;
        t = 0;
        while (consumed < target && t < 40 * n) begin
            cycle(1'b0, 1'b0, 1'b0, '0);
            t++;
        end
        require(consumed >= target, "timed out waiting for instructions at decode");
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%-12s ok", name);
        end else begin
            tests_failed++;
            $display("%-12s failed, %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic reset_sequence();
        int t;
        rst = 1'b1;
        repeat (9) begin
            @(negedge clk);
            check_quiet();
        end
        @(negedge clk);
        rst = 1'b0;  // tenth reset edge has passed
        check_quiet();  // first cycle after reset
        t = 0;
        while (!arvalid && t < 20) begin
            cycle(1'b0, 1'b0, 1'b0, '0);
            t++;
        end
        require(arvalid, "timed out waiting for the first read address");
        compare_word("araddr", araddr, fetch_pkg::reset_pc);
    endtask

    task automatic stall_pulses();
        repeat (80) begin
            stim_rng = xorshift32(stim_rng);
            cycle(stim_rng[2:0] < 3'd3, 1'b0, 1'b0, '0);
        end
        wait_consumed(4);
    endtask

    task automatic bubble_pulses();
        repeat (80) begin
            stim_rng = xorshift32(stim_rng);
            cycle(1'b0, stim_rng[2:0] < 3'd3, 1'b0, '0);
        end
        wait_consumed(4);
    endtask

    task automatic redirect_cases();
        int t;
        int idle;
        t = 0;
        while (!rready && t < 50) begin  // read outstanding with the buffer empty
            cycle(1'b0, 1'b0, 1'b0, '0);
            t++;
        end
        require(rready, "timed out waiting for an outstanding read");
        cycle(1'b0, 1'b0, 1'b1, 32'h8000_1400);
        wait_consumed(5);
        t = 0;
        while (!arvalid && t < 50) begin  // address not yet accepted
            cycle(1'b0, 1'b0, 1'b0, '0);
            t++;
        end
        require(arvalid, "timed out waiting for a pending read address");
        cycle(1'b0, 1'b0, 1'b1, 32'h8000_0200);
        wait_consumed(5);
        // stall until the buffer fills and the bus goes quiet
        t = 0;
        idle = 0;
        while (idle < 2 && t < 50) begin
            cycle(1'b1, 1'b0, 1'b0, '0);
            idle = (!arvalid && !rready) ? idle + 1 : 0;
            t++;
        end
        require(idle >= 2, "fetch buffer did not fill under stall");
        cycle(1'b0, 1'b0, 1'b1, 32'h8000_1100);
        wait_consumed(5);
    endtask

    task automatic fault_read();
        fault_seen = 1'b0;
        cycle(1'b0, 1'b0, 1'b1, err_addr - 32'd8);
        wait_consumed(4);
        require(fault_seen, "faulting read never reached decode");
    endtask

    initial begin
        reset_sequence();
        report_test("reset");
        wait_consumed(20);
        report_test("sequential");
        stall_pulses();
        report_test("stall");
        bubble_pulses();
        report_test("bubble");
        redirect_cases();
        report_test("redirect");
        fault_read();
        report_test("fault");
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, i_dut.u_chk.fail_count);
        if (errors == 0 && i_dut.u_chk.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
